// ==== accessIf.sv ====
interface accessIf import lsuPkg::*;
    ();

    logic    valid;
    logic    regWrite;
    logic    memToReg;
    opcode_t op;
    regNum_t wreg;
    word_t   aluResult;
    word_t   readData;

    modport source (
        output valid,
        output regWrite,
        output memToReg,
        output op,
        output wreg,
        output aluResult,
        output readData
    );

    modport sink (
        input valid,
        input regWrite,
        input memToReg,
        input op,
        input wreg,
        input aluResult,
        input readData
    );

endinterface

// ==== loadWriteback.sv ====
module loadWriteback import lsuPkg::*; (
    input  logic     dStall,
    writebackIf.sink wb,
    output byteEn_t  wbRfWen,
    output regNum_t  wbRfWnum,
    output word_t    wbRfWdata
);

    memWord_t         rdWord;
    logic [halfW-1:0] halfSel;
    logic [byteW-1:0] byteSel;
    word_t            loadData;

    // pick the addressed half and byte from the returned word
    always_comb begin
        rdWord.word = wb.readData;
        halfSel     = rdWord.half[wb.aluResult[1]];
        byteSel     = rdWord.lane[wb.aluResult[1:0]];
    end

    // extension by load kind
    always_comb begin
        case (wb.op)
            opLw:    loadData = rdWord.word;
            opLh:    loadData = {{(wordW-halfW){halfSel[halfW-1]}}, halfSel};
            opLhu:   loadData = {{(wordW-halfW){1'b0}}, halfSel};
            opLb:    loadData = {{(wordW-byteW){byteSel[byteW-1]}}, byteSel};
            opLbu:   loadData = {{(wordW-byteW){1'b0}}, byteSel};
            default: loadData = '0;
        endcase
    end

    assign wbRfWdata = wb.memToReg ? loadData : wb.aluResult;
    assign wbRfWnum  = wb.wreg;

    // no write reported while the data side stalls
    assign wbRfWen = {byteLanes{wb.valid & wb.regWrite & ~dStall}};

endmodule

// ==== lsuPkg.sv ====
package lsuPkg;

    // datapath widths
    localparam int wordW     = 32;
    localparam int halfW     = 16;
    localparam int byteW     = 8;
    localparam int byteLanes = wordW / byteW;
    localparam int regNumW   = 5;
    localparam int opcodeW   = 6;
    localparam int excCodeW  = 5;

    typedef logic [wordW-1:0]     word_t;
    typedef logic [regNumW-1:0]   regNum_t;
    typedef logic [byteLanes-1:0] byteEn_t;
    typedef logic [opcodeW-1:0]   opcode_t;
    typedef logic [excCodeW-1:0]  excCode_t;

    // one memory word seen as a whole, as halves or as byte lanes
    typedef union packed {
        word_t                              word;
        logic [1:0][halfW-1:0]              half;
        logic [byteLanes-1:0][byteW-1:0]    lane;
    } memWord_t;

    // MIPS primary opcodes for loads
    localparam opcode_t opLb  = 6'h20;
    localparam opcode_t opLh  = 6'h21;
    localparam opcode_t opLw  = 6'h23;
    localparam opcode_t opLbu = 6'h24;
    localparam opcode_t opLhu = 6'h25;

    // and for stores
    localparam opcode_t opSb  = 6'h28;
    localparam opcode_t opSh  = 6'h29;
    localparam opcode_t opSw  = 6'h2B;

    // address error on load or fetch
    localparam excCode_t excAdel = 5'd4;
    // address error on store
    localparam excCode_t excAdes = 5'd5;

endpackage

// ==== lsuTb.sv ====
module lsuTb import lsuPkg::*; ();

    localparam int unsigned seed = 32'h42bd_799c;
    localparam int numStores     = 24;
    localparam int numLoadRounds = 2;
    localparam int numAlu        = 10;
    localparam int numStallTests = 6;
    localparam int maxStall      = 5;
    localparam opcode_t opAddiu  = 6'h09;
    // reset, 13 loads per round, 12 misaligned requests, stall spans, idle and margin
    localparam int timeoutCycles = 4 + numStores + numLoadRounds * 13 + 12 + numAlu
        + numStallTests * (maxStall + 2) + 30;

    logic     clk, reset, reqValid, regWrite, dStall;
    logic     memEn, excValid;
    opcode_t  reqOp;
    word_t    reqAddr, storeData, readData, writeData, badVAddr, wbRfWdata;
    regNum_t  wreg, wbRfWnum;
    byteEn_t  memWen, wbRfWen;
    excCode_t excCode;
    word_t    mem [16];
    word_t    laneMask;
    int       errors;
    int       checks;

    // expectation for the request on the bus this cycle
    logic     curValid, expMemEn, expExc;
    string    curName;
    byteEn_t  expWen, expRfWen;
    word_t    expWdata, expWbData;
    excCode_t expCode;
    regNum_t  expWnum;

    tbClock tbClock_inst (.clk(clk));

    lsuTop lsuTop_inst (.*);

    // 16-word memory with lanes written at the rising edge and read combinationally
    assign readData = mem[reqAddr[5:2]];
    assign laneMask = {{8{memWen[3]}}, {8{memWen[2]}}, {8{memWen[1]}}, {8{memWen[0]}}};

    always @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 16; i++) begin
                mem[i[3:0]] <= {i[3:0], 4'h7, i[3:0] ^ 4'h5, 4'hC, ~i[3:0], 4'h1,
                    i[3:0] ^ 4'hA, 4'h9};
            end
        end else if (memEn) begin
            mem[reqAddr[5:2]] <= (mem[reqAddr[5:2]] & ~laneMask) | (writeData & laneMask);
        end
    end

    // expected response of one valid request
    function automatic void expectedResult(input opcode_t op, input word_t addr,
            input word_t sdata, input word_t memWord, input logic rw,
            output logic eMemEn, output byteEn_t eWen, output word_t eWdata,
            output logic eExc, output excCode_t eCode, output byteEn_t eRfWen,
            output word_t eWbData);
        int    size;
        logic  isLd;
        logic  isSt;
        word_t shifted;
        isLd    = op inside {opLb, opLh, opLw, opLbu, opLhu};
        isSt    = op inside {opSb, opSh, opSw};
        size    = (op inside {opLw, opSw}) ? 4 : (op inside {opLh, opLhu, opSh}) ? 2 : 1;
        eExc    = (isLd || isSt) && ((addr & word_t'(size - 1)) != 0);
        eCode   = isSt ? excAdes : excAdel;
        eMemEn  = (isLd || isSt) && !eExc;
        eRfWen  = (rw && !eExc) ? '1 : '0;
        eWen    = (isSt && !eExc) ? byteEn_t'(((1 << size) - 1) << addr[1:0]) : '0;
        eWdata  = (size == 4) ? sdata : (size == 2) ? {2{sdata[15:0]}} : {4{sdata[7:0]}};
        shifted = memWord >> {addr[1:0], 3'b000};
        if (!isLd) begin
            eWbData = addr;
        end else if (size == 4) begin
            eWbData = memWord;
        end else if (size == 2) begin
            eWbData = {{16{shifted[15] && op == opLh}}, shifted[15:0]};
        end else begin
            eWbData = {{24{shifted[7] && op == opLb}}, shifted[7:0]};
        end
    endfunction

    task automatic checkWord(input string name, input word_t expV, input word_t actV);
        checks++;
        if (actV !== expV) begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, expV, actV);
        end
    endtask

    task automatic checkWen(input string name, input byteEn_t expV, input byteEn_t actV);
        checks++;
        if (actV !== expV) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, expV, actV);
        end
    endtask

    task automatic checkExc(input string name, input excCode_t expV, input excCode_t actV);
        checks++;
        if (actV !== expV) begin
            errors++;
            $display("[FAIL] %s: expected %0d, actual %0d", name, expV, actV);
        end
    endtask

    task automatic checkReg(input string name, input regNum_t expV, input regNum_t actV);
        checks++;
        if (actV !== expV) begin
            errors++;
            $display("[FAIL] %s: expected r%0d, actual r%0d", name, expV, actV);
        end
    endtask

    task automatic checkFlag(input string name, input logic expV, input logic actV);
        checks++;
        if (actV !== expV) begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, expV, actV);
        end
    endtask

    task automatic driveReq(input string name, input opcode_t op, input word_t addr,
            input word_t sdata, input logic rw, input regNum_t wnum, input logic stall);
        @(negedge clk);
        reqValid  = 1'b1;
        reqOp     = op;
        reqAddr   = addr;
        storeData = sdata;
        regWrite  = rw;
        wreg      = wnum;
        dStall    = stall;
        expectedResult(op, addr, sdata, mem[addr[5:2]], rw, expMemEn, expWen, expWdata,
            expExc, expCode, expRfWen, expWbData);
        curValid = 1'b1;
        curName  = name;
        expWnum  = wnum;
    endtask

    task automatic idleCycle();
        @(negedge clk);
        reqValid = 1'b0;
        dStall   = 1'b0;
        curValid = 1'b0;
    endtask

    // request outputs checked in their own cycle and writeback after the capture edge
    initial begin : compare
        logic    heldValid;
        logic    heldRw;
        word_t   heldData;
        regNum_t heldWnum;
        string   heldName;
        byteEn_t wenNow;
        heldValid = 1'b0;
        heldRw    = 1'b0;
        heldName  = "reset";
        forever begin
            @(negedge clk);
            #2;
            wenNow = (heldValid && heldRw && !dStall) ? '1 : '0;
            checkWen({heldName, " wbRfWen"}, wenNow, wbRfWen);
            if (wenNow != 0) begin
                checkWord({heldName, " wbRfWdata"}, heldData, wbRfWdata);
                checkReg({heldName, " wbRfWnum"}, heldWnum, wbRfWnum);
            end
            checkFlag({curName, " memEn"}, curValid && expMemEn, memEn);
            checkFlag({curName, " excValid"}, curValid && expExc, excValid);
            if (curValid) begin
                checkWen({curName, " memWen"}, expWen, memWen);
                if (expExc) begin
                    checkExc({curName, " excCode"}, expCode, excCode);
                    checkWord({curName, " badVAddr"}, reqAddr, badVAddr);
                end else if (expWen != 0) begin
                    checkWord({curName, " writeData"}, expWdata, writeData);
                end
            end
            // model of the pipeline register at the coming edge
            if (reset) begin
                heldValid = 1'b0;
            end else if (!dStall) begin
                heldValid = curValid;
                heldRw    = expRfWen != 0;
                heldData  = expWbData;
                heldWnum  = expWnum;
                heldName  = curName;
            end
        end
    end

    initial begin : stimulus
        opcode_t     loadOps [5];
        opcode_t     misOps [5];
        word_t       base;
        word_t       sdata;
        int          step;
        int          span;
        void'($urandom(seed));
        loadOps   = '{opLw, opLh, opLhu, opLb, opLbu};
        misOps    = '{opLw, opLh, opLhu, opSw, opSh};
        errors    = 0;
        checks    = 0;
        reset     = 1'b1;
        // a writing request held during reset must never reach the writeback port
        reqValid  = 1'b1;
        reqOp     = opAddiu;
        reqAddr   = '0;
        storeData = '0;
        regWrite  = 1'b1;
        wreg      = '0;
        dStall    = 1'b0;
        curValid  = 1'b0;
        curName   = "reset";
        repeat (4) @(negedge clk);
        reset    = 1'b0;
        reqValid = 1'b0;
        regWrite = 1'b0;
        curName  = "idle after reset";
        repeat (2) idleCycle();

        // stores of every size at aligned offsets
        repeat (numStores) begin
            base  = $urandom() & 32'h0000_003C;
            sdata = $urandom();
            case ($urandom_range(0, 2))
                0: driveReq("sw", opSw, base, sdata, 1'b0, '0, 1'b0);
                1: driveReq("sh", opSh, base + 2 * $urandom_range(0, 1), sdata, 1'b0, '0, 1'b0);
                default: driveReq("sb", opSb, base + $urandom_range(0, 3), sdata, 1'b0, '0, 1'b0);
            endcase
        end

        // every load kind at every legal offset
        repeat (numLoadRounds) begin
            foreach (loadOps[k]) begin
                step = (loadOps[k] == opLw) ? 4 : (loadOps[k] inside {opLh, opLhu}) ? 2 : 1;
                for (int off = 0; off < 4; off += step) begin
                    driveReq("load", loadOps[k], ($urandom() & 32'h3C) + off, $urandom(), 1'b1,
                        regNum_t'($urandom_range(1, 31)), 1'b0);
                end
            end
        end

        // misaligned word and halfword accesses
        foreach (misOps[k]) begin
            for (int off = 1; off < 4; off++) begin
                if (misOps[k] inside {opLw, opSw} || off % 2 == 1) begin
                    driveReq("misaligned", misOps[k], ($urandom() & 32'h3C) + off, $urandom(),
                        1'b1, regNum_t'($urandom_range(1, 31)), 1'b0);
                end
            end
        end

        // non-memory requests with register write on or off
        repeat (numAlu) begin
            driveReq("alu", opAddiu, $urandom(), $urandom(), $urandom_range(0, 1) == 1,
                regNum_t'($urandom_range(0, 31)), 1'b0);
        end

        // a held load must keep its data while a stalled store rewrites the word
        repeat (numStallTests) begin
            base  = $urandom() & 32'h3C;
            sdata = $urandom();
            span  = $urandom_range(1, maxStall);
            driveReq("held load", opLw, base, '0, 1'b1, regNum_t'($urandom_range(1, 31)), 1'b0);
            repeat (span) driveReq("stalled store", opSw, base, sdata, 1'b0, '0, 1'b1);
            driveReq("stalled store", opSw, base, sdata, 1'b0, '0, 1'b0);
        end

        repeat (3) idleCycle();
        #4;
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin : watchdog
        #(timeoutCycles * 10);
        $display("timeout: the tests did not finish within %0d cycles", timeoutCycles);
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

// ==== lsuTop.sv ====
module lsuTop import lsuPkg::*; (
    input  logic     clk,
    input  logic     reset,

    input  logic     reqValid,
    input  opcode_t  reqOp,
    input  word_t    reqAddr,
    input  word_t    storeData,
    input  logic     regWrite,
    input  regNum_t  wreg,

    output logic     memEn,
    output byteEn_t  memWen,
    output word_t    writeData,
    input  word_t    readData,
    input  logic     dStall,

    output logic     excValid,
    output excCode_t excCode,
    output word_t    badVAddr,

    output byteEn_t  wbRfWen,
    output regNum_t  wbRfWnum,
    output word_t    wbRfWdata
);

    accessIf    accBus ();
    writebackIf wbBus ();

    // memory stage, combinational
    memAccess memAccess_inst (
        .reqValid  (reqValid),
        .reqOp     (reqOp),
        .reqAddr   (reqAddr),
        .storeData (storeData),
        .regWrite  (regWrite),
        .wreg      (wreg),
        .readData  (readData),
        .memEn     (memEn),
        .memWen    (memWen),
        .writeData (writeData),
        .excValid  (excValid),
        .excCode   (excCode),
        .badVAddr  (badVAddr),
        .acc       (accBus.source)
    );

    memWbReg memWbReg_inst (
        .clk    (clk),
        .reset  (reset),
        .dStall (dStall),
        .acc    (accBus.sink),
        .wb     (wbBus.source)
    );

    // writeback stage and debug port
    loadWriteback loadWriteback_inst (
        .dStall    (dStall),
        .wb        (wbBus.sink),
        .wbRfWen   (wbRfWen),
        .wbRfWnum  (wbRfWnum),
        .wbRfWdata (wbRfWdata)
    );

endmodule

// ==== memAccess.sv ====
module memAccess import lsuPkg::*; (
    input  logic     reqValid,
    input  opcode_t  reqOp,
    input  word_t    reqAddr,
    input  word_t    storeData,
    input  logic     regWrite,
    input  regNum_t  wreg,
    input  word_t    readData,
    output logic     memEn,
    output byteEn_t  memWen,
    output word_t    writeData,
    output logic     excValid,
    output excCode_t excCode,
    output word_t    badVAddr,
    accessIf.source  acc
);

    logic     isLoad;
    logic     isStore;
    logic     isHalf;
    logic     isWord;
    logic     misaligned;
    logic     fault;
    logic     storeOk;
    memWord_t storeWord;
    memWord_t replWord;

    // opcode decode into direction and access size
    always_comb begin
        isLoad  = 1'b0;
        isStore = 1'b0;
        isHalf  = 1'b0;
        isWord  = 1'b0;
        case (reqOp)
            opLb, opLbu: begin
                isLoad = 1'b1;
            end
            opLh, opLhu: begin
                isLoad = 1'b1;
                isHalf = 1'b1;
            end
            opLw: begin
                isLoad = 1'b1;
                isWord = 1'b1;
            end
            opSb: begin
                isStore = 1'b1;
            end
            opSh: begin
                isStore = 1'b1;
                isHalf  = 1'b1;
            end
            opSw: begin
                isStore = 1'b1;
                isWord  = 1'b1;
            end
            default: ;
        endcase
    end

    // byte accesses can never be misaligned
    assign misaligned = (isWord & (|reqAddr[1:0])) | (isHalf & reqAddr[0]);
    assign fault      = reqValid & (isLoad | isStore) & misaligned;
    assign storeOk    = reqValid & isStore & ~fault;

    assign excValid = fault;
    assign excCode  = fault ? (isStore ? excAdes : excAdel) : '0;
    assign badVAddr = fault ? reqAddr : '0;
    assign memEn    = reqValid & (isLoad | isStore) & ~fault;

    // lane enables and replicated store data
    always_comb begin
        storeWord.word = storeData;
        replWord.word  = '0;
        memWen         = '0;
        if (storeOk) begin
            if (isWord) begin
                replWord.word = storeWord.word;
                memWen        = '1;
            end else if (isHalf) begin
                replWord.half = {2{storeWord.half[0]}};
                memWen        = reqAddr[1] ? 4'b1100 : 4'b0011;
            end else begin
                replWord.lane = {byteLanes{storeWord.lane[0]}};
                memWen        = byteEn_t'(4'b0001 << reqAddr[1:0]);
            end
        end
    end

    assign writeData = replWord.word;

    // request handed on to the memory/writeback register
    assign acc.valid     = reqValid;
    assign acc.regWrite  = regWrite & ~fault;
    assign acc.memToReg  = isLoad;
    assign acc.op        = reqOp;
    assign acc.wreg      = wreg;
    assign acc.aluResult = reqAddr;
    assign acc.readData  = readData;

endmodule

// ==== memWbReg.sv ====
module memWbReg (
    input  logic       clk,
    input  logic       reset,
    input  logic       dStall,
    accessIf.sink      acc,
    writebackIf.source wb
);

    // control bit, cleared on reset
    always_ff @(posedge clk) begin
        if (reset) begin
            wb.valid <= 1'b0;
        end else if (!dStall) begin
            wb.valid <= acc.valid;
        end
    end

    // payload only moves when the data side is not stalled
    always_ff @(posedge clk) begin
        if (!dStall) begin
            wb.regWrite  <= acc.regWrite;
            wb.memToReg  <= acc.memToReg;
            wb.op        <= acc.op;
            wb.wreg      <= acc.wreg;
            wb.aluResult <= acc.aluResult;
            wb.readData  <= acc.readData;
        end
    end

endmodule

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary -f src.f --top-module lsuTb -o lsuSim
./obj_dir/lsuSim > sim.log
cat sim.log
if grep -q "^STATUS: PASS$" sim.log; then
    exit 0
fi
exit 1

// ==== src.f ====
lsuPkg.sv
accessIf.sv
writebackIf.sv
memAccess.sv
memWbReg.sv
loadWriteback.sv
lsuTop.sv
tbClock.sv
lsuTb.sv

// ==== tbClock.sv ====
module tbClock (
    output logic clk
);

    // free-running clock, period of 10 units
    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

endmodule

// ==== writebackIf.sv ====
interface writebackIf import lsuPkg::*;
    ();

    // registered copy of the memory stage request
    logic    valid;
    logic    regWrite;
    logic    memToReg;
    opcode_t op;
    regNum_t wreg;
    word_t   aluResult;
    word_t   readData;

    modport source (
        output valid, regWrite, memToReg, op, wreg, aluResult, readData
    );

    modport sink (
        input valid, regWrite, memToReg, op, wreg, aluResult, readData
    );

endinterface
